//--- verilog/pipe_drp_pkg.sv
package pipe_drp_pkg;

    // DRP port geometry
    localparam int DRP_ADDR_W = 9;                       // attribute address bits
    localparam int DRP_DATA_W = 16;                      // register word bits

    // link rate input, 2 selects Gen3
    localparam int RATE_W = 2;

    // attribute register address
    typedef logic [DRP_ADDR_W-1:0] drp_addr_t;

    // read data, write data, keep mask and field value share this type
    typedef logic [DRP_DATA_W-1:0] drp_data_t;

    // attribute table entry number
    typedef logic [3:0] drp_index_t;

    // last entry of a full pass
    localparam drp_index_t INDEX_LAST = 4'd13;

endpackage

//--- verilog/drp_input_sync.sv
`timescale 1ns/1ps

module drp_input_sync
(
    input  logic                               DRP_CLK,
    input  logic                               DRP_RST_N,
    input  logic                               drp_start,
    input  logic [pipe_drp_pkg::RATE_W-1:0]    drp_rate,
    input  logic                               drp_x16x20_mode,
    input  logic                               drp_x16,
    input  pipe_drp_pkg::drp_data_t            drp_do,
    input  logic                               drp_rdy,
    output logic                               start_sync,
    output logic [pipe_drp_pkg::RATE_W-1:0]    rate_sync,
    output logic                               x16x20_sync,
    output logic                               x16_sync,
    output pipe_drp_pkg::drp_data_t            do_sync,
    output logic                               rdy_sync
);
    import pipe_drp_pkg::*;

    // first stage, may go metastable
    (* ASYNC_REG = "TRUE" *) logic              start_r1;
    (* ASYNC_REG = "TRUE" *) logic [RATE_W-1:0] rate_r1;
    (* ASYNC_REG = "TRUE" *) logic              x16x20_r1;
    (* ASYNC_REG = "TRUE" *) logic              x16_r1;
    (* ASYNC_REG = "TRUE" *) drp_data_t         do_r1;
    (* ASYNC_REG = "TRUE" *) logic              rdy_r1;

    // second stage feeds the outputs
    (* ASYNC_REG = "TRUE" *) logic              start_r2;
    (* ASYNC_REG = "TRUE" *) logic [RATE_W-1:0] rate_r2;
    (* ASYNC_REG = "TRUE" *) logic              x16x20_r2;
    (* ASYNC_REG = "TRUE" *) logic              x16_r2;
    (* ASYNC_REG = "TRUE" *) drp_data_t         do_r2;
    (* ASYNC_REG = "TRUE" *) logic              rdy_r2;

    always_ff @(posedge DRP_CLK)
    begin
        if (!DRP_RST_N)
        begin
            start_r1  <= 1'b0;
            rate_r1   <= '0;
            x16x20_r1 <= 1'b0;
            x16_r1    <= 1'b0;
            do_r1     <= '0;
            rdy_r1    <= 1'b0;
            start_r2  <= 1'b0;
            rate_r2   <= '0;
            x16x20_r2 <= 1'b0;
            x16_r2    <= 1'b0;
            do_r2     <= '0;
            rdy_r2    <= 1'b0;
        end
        else
        begin
            start_r1  <= drp_start;
            rate_r1   <= drp_rate;
            x16x20_r1 <= drp_x16x20_mode;
            x16_r1    <= drp_x16;
            do_r1     <= drp_do;                    // same depth as rdy
            rdy_r1    <= drp_rdy;
            start_r2  <= start_r1;
            rate_r2   <= rate_r1;
            x16x20_r2 <= x16x20_r1;
            x16_r2    <= x16_r1;
            do_r2     <= do_r1;
            rdy_r2    <= rdy_r1;
        end
    end

    assign start_sync  = start_r2;
    assign rate_sync   = rate_r2;
    assign x16x20_sync = x16x20_r2;
    assign x16_sync    = x16_r2;
    assign do_sync     = do_r2;                     // lands with rdy_sync
    assign rdy_sync    = rdy_r2;

endmodule

//--- verilog/drp_attr_table.sv
`timescale 1ns/1ps

module drp_attr_table
#(
    parameter bit PLL_SEL_QPLL = 1'b0,
    parameter bit TXBUF_EN     = 1'b0,
    parameter bit RXBUF_EN     = 1'b1
)
(
    input  pipe_drp_pkg::drp_index_t           index,
    input  logic [pipe_drp_pkg::RATE_W-1:0]    rate_sync,
    input  logic                               x16x20_sync,
    input  logic                               x16_sync,
    output pipe_drp_pkg::drp_addr_t            attr_addr,
    output pipe_drp_pkg::drp_data_t            attr_keep,
    output pipe_drp_pkg::drp_data_t            attr_value
);
    import pipe_drp_pkg::*;

    // keep masks, zeros on the field being patched
    localparam drp_data_t KEEP_B6_4  = 16'hFF8F;
    localparam drp_data_t KEEP_B2_0  = 16'hFFF8;
    localparam drp_data_t KEEP_B4    = 16'hFFEF;
    localparam drp_data_t KEEP_B13_11 = 16'hC7FF;
    localparam drp_data_t KEEP_B14   = 16'hBFFF;
    localparam drp_data_t KEEP_B11   = 16'hF7FF;
    localparam drp_data_t KEEP_B7    = 16'hFF7F;
    localparam drp_data_t KEEP_B6    = 16'hFFBF;
    localparam drp_data_t KEEP_B4_0  = 16'hFFE0;
    localparam drp_data_t KEEP_B1    = 16'hFFFD;

    // out dividers, QPLL runs at twice the CPLL rate
    localparam drp_data_t TXOUT_DIV_GEN12 = PLL_SEL_QPLL ? 16'h0020 : 16'h0010;
    localparam drp_data_t RXOUT_DIV_GEN12 = PLL_SEL_QPLL ? 16'h0002 : 16'h0001;

    logic gen3;
    logic txbuf_use;
    logic rxbuf_bypass;

    assign gen3         = (rate_sync == 2'd2);
    assign txbuf_use    = TXBUF_EN && !gen3;         // TX buffer only below Gen3
    assign rxbuf_bypass = gen3 && !RXBUF_EN;         // RX buffer off only at Gen3

    always_comb
    begin
        case (index)
            4'd0:
            begin
                if (x16x20_sync)
                begin
                    attr_addr  = 9'h011;             // RX data width, bit 11 only
                    attr_keep  = KEEP_B11;
                    attr_value = x16_sync ? 16'h0000 : 16'h0800;
                end
                else
                begin
                    attr_addr  = 9'h088;             // TX out divider
                    attr_keep  = KEEP_B6_4;
                    attr_value = gen3 ? 16'h0000 : TXOUT_DIV_GEN12;
                end
            end
            4'd1:
            begin
                attr_addr  = 9'h088;                 // RX out divider
                attr_keep  = KEEP_B2_0;
                attr_value = gen3 ? 16'h0000 : RXOUT_DIV_GEN12;
            end
            4'd2:
            begin
                attr_addr  = 9'h06B;                 // TX data width
                attr_keep  = KEEP_B2_0;
                attr_value = gen3 ? 16'h0004 : 16'h0003;
            end
            4'd3:
            begin
                attr_addr  = 9'h06B;                 // TX internal width
                attr_keep  = KEEP_B4;
                attr_value = gen3 ? 16'h0010 : 16'h0000;
            end
            4'd4:
            begin
                attr_addr  = 9'h011;                 // RX data width
                attr_keep  = KEEP_B13_11;
                attr_value = gen3 ? 16'h2000 : 16'h1800;
            end
            4'd5:
            begin
                attr_addr  = 9'h011;                 // RX internal width
                attr_keep  = KEEP_B14;
                attr_value = gen3 ? 16'h4000 : 16'h0000;
            end
            4'd6:
            begin
                attr_addr  = 9'h01C;                 // TX buffer enable
                attr_keep  = KEEP_B14;
                attr_value = txbuf_use ? 16'h4000 : 16'h0000;
            end
            4'd7:
            begin
                attr_addr  = 9'h09D;                 // RX buffer enable
                attr_keep  = KEEP_B1;
                attr_value = rxbuf_bypass ? 16'h0000 : 16'h0002;
            end
            4'd8:
            begin
                attr_addr  = 9'h059;                 // TX clock select, usrclk when bypassed
                attr_keep  = KEEP_B7;
                attr_value = txbuf_use ? 16'h0000 : 16'h0080;
            end
            4'd9:
            begin
                attr_addr  = 9'h059;                 // RX clock select
                attr_keep  = KEEP_B6;
                attr_value = rxbuf_bypass ? 16'h0040 : 16'h0000;
            end
            4'd10:
            begin
                attr_addr  = 9'h044;                 // clock correction use
                attr_keep  = KEEP_B14;
                attr_value = gen3 ? 16'h0000 : 16'h4000;
            end
            4'd11:
            begin
                attr_addr  = 9'h019;                 // TX drive mode
                attr_keep  = KEEP_B4_0;
                attr_value = gen3 ? 16'h0002 : 16'h0001;
            end
            4'd12:
            begin
                attr_addr  = 9'h0A7;                 // CDR hold in elec idle
                attr_keep  = KEEP_B11;
                attr_value = gen3 ? 16'h0000 : 16'h0800;
            end
            INDEX_LAST:
            begin
                attr_addr  = 9'h01E;                 // DFE/LPM hold in elec idle
                attr_keep  = KEEP_B14;
                attr_value = gen3 ? 16'h0000 : 16'h4000;
            end
            default:
            begin
                attr_addr  = '0;                     // out of range, word passes unchanged
                attr_keep  = '1;
                attr_value = '0;
            end
        endcase
    end

endmodule

//--- verilog/drp_rmw_sequencer.sv
`timescale 1ns/1ps

module drp_rmw_sequencer
#(
    parameter int LOAD_CNT_MAX = 1
)
(
    input  logic                        DRP_CLK,
    input  logic                        DRP_RST_N,
    input  logic                        start_sync,
    input  logic                        x16x20_sync,
    input  logic                        rdy_sync,
    input  pipe_drp_pkg::drp_data_t     do_sync,
    input  pipe_drp_pkg::drp_addr_t     attr_addr,
    input  pipe_drp_pkg::drp_data_t     attr_keep,
    input  pipe_drp_pkg::drp_data_t     attr_value,
    output pipe_drp_pkg::drp_index_t    index,
    output pipe_drp_pkg::drp_addr_t     drp_addr,
    output logic                        drp_en,
    output logic                        drp_we,
    output pipe_drp_pkg::drp_data_t     drp_di,
    output logic                        drp_done
);
    import pipe_drp_pkg::*;

    localparam int LOAD_CNT_W = (LOAD_CNT_MAX > 0) ? $clog2(LOAD_CNT_MAX + 1) : 1;
    localparam logic [LOAD_CNT_W-1:0] LOAD_LAST = LOAD_CNT_W'(LOAD_CNT_MAX);

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_LOAD,
        ST_READ,
        ST_READ_WAIT,
        ST_WRITE,
        ST_WRITE_WAIT,
        ST_DONE
    } state_t;

    state_t                state;
    logic [LOAD_CNT_W-1:0] load_cnt;
    logic                  pass_end;

    // x16/x20 mode stops after the single data-width entry
    assign pass_end = (index == INDEX_LAST) || (x16x20_sync && (index == '0));

    // load counter, lets the table outputs settle into drp_addr
    always_ff @(posedge DRP_CLK)
    begin
        if (!DRP_RST_N)
            load_cnt <= '0;
        else if ((state == ST_LOAD) && (load_cnt != LOAD_LAST))
            load_cnt <= load_cnt + 1'b1;
        else if (state != ST_LOAD)
            load_cnt <= '0;
    end

    // address and merged word follow the table every cycle
    always_ff @(posedge DRP_CLK)
    begin
        if (!DRP_RST_N)
        begin
            drp_addr <= '0;
            drp_di   <= '0;
        end
        else
        begin
            drp_addr <= attr_addr;
            drp_di   <= (do_sync & attr_keep) | attr_value;
        end
    end

    always_ff @(posedge DRP_CLK)
    begin
        if (!DRP_RST_N)
        begin
            state    <= ST_IDLE;
            index    <= '0;
            drp_done <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    index <= '0;
                    if (start_sync)
                    begin
                        state    <= ST_LOAD;
                        drp_done <= 1'b0;
                    end
                    else
                        drp_done <= 1'b1;       // sequencer at rest
                end
                ST_LOAD:
                begin
                    if (load_cnt == LOAD_LAST)
                        state <= ST_READ;
                end
                ST_READ:
                    state <= ST_READ_WAIT;      // read enable pulse
                ST_READ_WAIT:
                begin
                    if (rdy_sync)
                        state <= ST_WRITE;      // drp_di picks up do_sync here
                end
                ST_WRITE:
                    state <= ST_WRITE_WAIT;
                ST_WRITE_WAIT:
                begin
                    if (rdy_sync)
                        state <= ST_DONE;
                end
                ST_DONE:
                begin
                    if (pass_end)
                    begin
                        state <= ST_IDLE;
                        index <= '0;
                    end
                    else
                    begin
                        state <= ST_LOAD;
                        index <= index + drp_index_t'(1);
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                    index <= '0;
                end
            endcase
        end
    end

    assign drp_en = (state == ST_READ) || (state == ST_WRITE);
    assign drp_we = (state == ST_WRITE);

endmodule

//--- verilog/pipe_drp_top.sv
`timescale 1ns/1ps

module pipe_drp_top
#(
    parameter bit PLL_SEL_QPLL = 1'b0,
    parameter bit TXBUF_EN     = 1'b0,
    parameter bit RXBUF_EN     = 1'b1,
    parameter int LOAD_CNT_MAX = 1
)
(
    input  logic                               DRP_CLK,
    input  logic                               DRP_RST_N,
    input  logic                               drp_start,
    input  logic [pipe_drp_pkg::RATE_W-1:0]    drp_rate,
    input  logic                               drp_x16x20_mode,
    input  logic                               drp_x16,
    input  pipe_drp_pkg::drp_data_t            drp_do,
    input  logic                               drp_rdy,
    output pipe_drp_pkg::drp_addr_t            drp_addr,
    output logic                               drp_en,
    output pipe_drp_pkg::drp_data_t            drp_di,
    output logic                               drp_we,
    output logic                               drp_done
);
    import pipe_drp_pkg::*;

    logic              start_sync;
    logic [RATE_W-1:0] rate_sync;
    logic              x16x20_sync;
    logic              x16_sync;
    drp_data_t         do_sync;
    logic              rdy_sync;

    drp_index_t        index;                        // sequencer steers the table
    drp_addr_t         attr_addr;
    drp_data_t         attr_keep;
    drp_data_t         attr_value;

    drp_input_sync u_sync
    (
        .DRP_CLK         (DRP_CLK),
        .DRP_RST_N       (DRP_RST_N),
        .drp_start       (drp_start),
        .drp_rate        (drp_rate),
        .drp_x16x20_mode (drp_x16x20_mode),
        .drp_x16         (drp_x16),
        .drp_do          (drp_do),
        .drp_rdy         (drp_rdy),
        .start_sync      (start_sync),
        .rate_sync       (rate_sync),
        .x16x20_sync     (x16x20_sync),
        .x16_sync        (x16_sync),
        .do_sync         (do_sync),
        .rdy_sync        (rdy_sync)
    );

    drp_attr_table
    #(
        .PLL_SEL_QPLL (PLL_SEL_QPLL),
        .TXBUF_EN     (TXBUF_EN),
        .RXBUF_EN     (RXBUF_EN)
    )
    u_table
    (
        .index       (index),
        .rate_sync   (rate_sync),
        .x16x20_sync (x16x20_sync),
        .x16_sync    (x16_sync),
        .attr_addr   (attr_addr),
        .attr_keep   (attr_keep),
        .attr_value  (attr_value)
    );

    drp_rmw_sequencer
    #(
        .LOAD_CNT_MAX (LOAD_CNT_MAX)
    )
    u_seq
    (
        .DRP_CLK     (DRP_CLK),
        .DRP_RST_N   (DRP_RST_N),
        .start_sync  (start_sync),
        .x16x20_sync (x16x20_sync),
        .rdy_sync    (rdy_sync),
        .do_sync     (do_sync),
        .attr_addr   (attr_addr),
        .attr_keep   (attr_keep),
        .attr_value  (attr_value),
        .index       (index),
        .drp_addr    (drp_addr),
        .drp_en      (drp_en),
        .drp_we      (drp_we),
        .drp_di      (drp_di),
        .drp_done    (drp_done)
    );

endmodule

//--- verif/pipe_drp_assertions.sv
`timescale 1ns/1ps

module pipe_drp_assertions
(
    input logic DRP_CLK,
    input logic DRP_RST_N,
    input logic drp_en,
    input logic drp_we,
    input logic drp_rdy,
    input logic drp_done
);
    int   assert_fail_count = 0;
    logic access_open;                               // enable seen, ready not yet

    always_ff @(posedge DRP_CLK)
    begin
        if (!DRP_RST_N)
            access_open <= 1'b0;
        else if (drp_en)
            access_open <= 1'b1;
        else if (drp_rdy)
            access_open <= 1'b0;
    end

    a_en_single : assert property (@(posedge DRP_CLK) disable iff (!DRP_RST_N)
        drp_en |=> !drp_en)
    else
    begin
        $error("drp_en high for two cycles in a row");
        assert_fail_count++;
    end

    a_we_with_en : assert property (@(posedge DRP_CLK) disable iff (!DRP_RST_N)
        drp_we |-> drp_en)
    else
    begin
        $error("drp_we high without drp_en");
        assert_fail_count++;
    end

    a_one_access : assert property (@(posedge DRP_CLK) disable iff (!DRP_RST_N)
        drp_en |-> !access_open)
    else
    begin
        $error("new enable before ready of the previous access");
        assert_fail_count++;
    end

    a_done_idle : assert property (@(posedge DRP_CLK) disable iff (!DRP_RST_N)
        !(drp_done && drp_en))
    else
    begin
        $error("drp_done high during an access");
        assert_fail_count++;
    end

endmodule

bind pipe_drp_top pipe_drp_assertions u_assert
(
    .DRP_CLK   (DRP_CLK),
    .DRP_RST_N (DRP_RST_N),
    .drp_en    (drp_en),
    .drp_we    (drp_we),
    .drp_rdy   (drp_rdy),
    .drp_done  (drp_done)
);

//--- verif/tb_pipe_drp.sv
`timescale 1ns/1ps

module tb_pipe_drp;
    import pipe_drp_pkg::*;

    localparam bit PLL_SEL_QPLL   = 1'b0;
    localparam bit TXBUF_EN       = 1'b0;
    localparam bit RXBUF_EN       = 1'b1;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_ROWS       = 7;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 14 * 30 + RESET_CYCLES;

    // attribute table as given by the register map, field value kept unshifted
    localparam drp_addr_t ENTRY_ADDR [14] = '{9'h088, 9'h088, 9'h06B, 9'h06B, 9'h011, 9'h011,
        9'h01C, 9'h09D, 9'h059, 9'h059, 9'h044, 9'h019, 9'h0A7, 9'h01E};
    localparam int ENTRY_LSB [14]   = '{4, 0, 0, 4, 11, 14, 14, 1, 7, 6, 14, 0, 11, 14};
    localparam int ENTRY_WIDTH [14] = '{3, 3, 3, 1, 3, 1, 1, 1, 1, 1, 1, 5, 1, 1};

    typedef struct packed
    {
        logic [RATE_W-1:0] rate;
        logic              x16x20;
        logic              x16;
        logic [4:0]        writes;                   // expected write count
    } row_t;

    logic              DRP_CLK;
    logic              DRP_RST_N;
    logic              drp_start;
    logic [RATE_W-1:0] drp_rate;
    logic              drp_x16x20_mode;
    logic              drp_x16;
    drp_data_t         drp_do = '0;
    logic              drp_rdy = 1'b0;
    drp_addr_t         drp_addr;
    logic              drp_en;
    drp_data_t         drp_di;
    logic              drp_we;
    logic              drp_done;

    row_t      rows [NUM_ROWS];
    drp_data_t mem [0:511];                          // register file behind the port
    drp_data_t ref_mem [0:511];
    drp_addr_t exp_addr_q [$];
    drp_data_t exp_data_q [$];
    logic [31:0] rng_state = 32'd61;
    int check_count = 0;
    int mismatch_count = 0;
    int other_count = 0;
    int cycle_count = 0;
    int reads_seen = 0;
    int writes_seen = 0;

    // port model state
    logic      en_s;
    logic      we_s;
    drp_addr_t addr_s;
    drp_data_t di_s;
    logic      busy = 1'b0;
    logic      acc_we;
    drp_addr_t acc_addr;
    drp_data_t acc_data;
    int        wait_cnt;

    pipe_drp_top
    #(
        .PLL_SEL_QPLL (PLL_SEL_QPLL),
        .TXBUF_EN     (TXBUF_EN),
        .RXBUF_EN     (RXBUF_EN)
    )
    u_pipe_drp_top
    (
        .DRP_CLK         (DRP_CLK),
        .DRP_RST_N       (DRP_RST_N),
        .drp_start       (drp_start),
        .drp_rate        (drp_rate),
        .drp_x16x20_mode (drp_x16x20_mode),
        .drp_x16         (drp_x16),
        .drp_do          (drp_do),
        .drp_rdy         (drp_rdy),
        .drp_addr        (drp_addr),
        .drp_en          (drp_en),
        .drp_di          (drp_di),
        .drp_we          (drp_we),
        .drp_done        (drp_done)
    );

    initial
    begin
        DRP_CLK = 1'b0;
        forever #4 DRP_CLK = ~DRP_CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // field value per entry, Gen3 picks the second column
    function automatic int field_value(input int idx, input logic g3);
        case (idx)
            0, 1:    return g3 ? 0 : (PLL_SEL_QPLL ? 2 : 1);
            2, 4:    return g3 ? 4 : 3;
            3, 5:    return g3 ? 1 : 0;
            6:       return (TXBUF_EN && !g3) ? 1 : 0;
            7:       return (g3 && !RXBUF_EN) ? 0 : 1;
            8:       return (TXBUF_EN && !g3) ? 0 : 1;
            9:       return (g3 && !RXBUF_EN) ? 1 : 0;
            11:      return g3 ? 2 : 1;
            10, 12, 13: return g3 ? 0 : 1;
            default: return 0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("Fail at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_error(input string what);
        other_count++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic report_counts();
        $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 check_count, mismatch_count, other_count,
                 u_pipe_drp_top.u_assert.assert_fail_count);
    endtask

    // read-modify-write of every entry in order, on a copy of the register file
    task automatic build_expected(input logic [RATE_W-1:0] rate, input logic mode,
                                  input logic x16, input int entries);
        drp_addr_t addr;
        int        lsb;
        int        width;
        drp_data_t value;
        drp_data_t keep;
        logic      g3;
        g3 = (rate == 2'd2);
        for (int a = 0; a < 512; a++)
            ref_mem[a] = mem[a];
        exp_addr_q.delete();
        exp_data_q.delete();
        for (int idx = 0; idx < entries; idx++)
        begin
            if (mode)
            begin
                addr  = 9'h011;                      // rx data width bit only
                lsb   = 11;
                width = 1;
                value = x16 ? 16'h0000 : 16'h0001;
            end
            else
            begin
                addr  = ENTRY_ADDR[idx];
                lsb   = ENTRY_LSB[idx];
                width = ENTRY_WIDTH[idx];
                value = 16'(field_value(idx, g3));
            end
            keep = ~(((16'd1 << width) - 16'd1) << lsb);
            ref_mem[addr] = (ref_mem[addr] & keep) | (value << lsb);
            exp_addr_q.push_back(addr);
            exp_data_q.push_back(ref_mem[addr]);
        end
    endtask

    task automatic run_row(input int r);
        int reads_before;
        int writes_before;
        @(posedge DRP_CLK);
        #1;
        drp_rate        = rows[r].rate;
        drp_x16x20_mode = rows[r].x16x20;
        drp_x16         = rows[r].x16;
        repeat (3) @(posedge DRP_CLK);               // mode through the synchronizer
        build_expected(rows[r].rate, rows[r].x16x20, rows[r].x16, int'(rows[r].writes));
        reads_before  = reads_seen;
        writes_before = writes_seen;
        #1;
        drp_start = 1'b1;
        @(posedge DRP_CLK);
        #1;
        drp_start = 1'b0;
        do
            @(negedge DRP_CLK);
        while (drp_done !== 1'b0);
        do
            @(negedge DRP_CLK);
        while (drp_done !== 1'b1);
        check_value("write count", 32'(rows[r].writes), writes_seen - writes_before);
        check_value("read count", 32'(rows[r].writes), reads_seen - reads_before);
        check_value("writes still expected", 32'd0, exp_addr_q.size());
        for (int a = 0; a < 512; a++)
            check_value($sformatf("reg 0x%03h", a), 32'(ref_mem[a]), 32'(mem[a]));
    endtask

    always @(negedge DRP_CLK)
    begin
        en_s   = drp_en;
        we_s   = drp_we;
        addr_s = drp_addr;
        di_s   = drp_di;
    end

    // DRP port, answers each enable after a random delay
    always @(posedge DRP_CLK)
    begin
        #1;
        drp_rdy = 1'b0;
        if (busy)
        begin
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0)
            begin
                busy = 1'b0;
                if (acc_we)
                    mem[acc_addr] = acc_data;
                else
                    drp_do = mem[acc_addr];          // held until the next access
                drp_rdy = 1'b1;
            end
        end
        if (en_s)
        begin
            if (busy)
                report_error("enable arrived while an access was still outstanding");
            if (exp_addr_q.size() == 0)
                report_error("access to a register the sequence should not touch");
            else
            begin
                check_value("drp_addr", 32'(exp_addr_q[0]), 32'(addr_s));
                if (we_s)
                begin
                    check_value("drp_di", 32'(exp_data_q[0]), 32'(di_s));
                    void'(exp_addr_q.pop_front());
                    void'(exp_data_q.pop_front());
                end
            end
            if (we_s)
                writes_seen++;
            else
                reads_seen++;
            busy     = 1'b1;
            acc_we   = we_s;
            acc_addr = addr_s;
            acc_data = di_s;
            rng_state = xorshift32(rng_state);
            wait_cnt  = 1 + int'(rng_state % 32'd6);
            rng_state = xorshift32(rng_state);
            drp_do    = rng_state[15:0];             // junk until ready
        end
    end

    initial
    begin
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge DRP_CLK);
            cycle_count++;
        end
        report_error($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        report_counts();
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        DRP_RST_N       = 1'b0;
        drp_start       = 1'b0;
        drp_rate        = '0;
        drp_x16x20_mode = 1'b0;
        drp_x16         = 1'b0;
        rows[0] = '{2'd0, 1'b0, 1'b0, 5'd14};        // gen1
        rows[1] = '{2'd1, 1'b0, 1'b0, 5'd14};        // gen2
        rows[2] = '{2'd2, 1'b0, 1'b0, 5'd14};        // gen3
        rows[3] = '{2'd2, 1'b0, 1'b0, 5'd14};        // same again after done
        rows[4] = '{2'd0, 1'b1, 1'b1, 5'd1};
        rows[5] = '{2'd2, 1'b1, 1'b0, 5'd1};
        rows[6] = '{2'd3, 1'b0, 1'b0, 5'd14};        // rate 3 is not gen3
        for (int a = 0; a < 512; a++)
        begin
            rng_state = xorshift32(rng_state);
            mem[a] = rng_state[31:16] ^ 16'(a);
        end
        repeat (RESET_CYCLES - 1) @(posedge DRP_CLK);
        @(negedge DRP_CLK);
        check_value("drp_en", 32'd0, 32'(drp_en));
        check_value("drp_we", 32'd0, 32'(drp_we));
        check_value("drp_done", 32'd0, 32'(drp_done));
        check_value("drp_addr", 32'd0, 32'(drp_addr));
        check_value("drp_di", 32'd0, 32'(drp_di));
        @(posedge DRP_CLK);
        #1;
        DRP_RST_N = 1'b1;
        do
            @(negedge DRP_CLK);
        while (drp_done !== 1'b1);
        repeat (20)
        begin
            @(negedge DRP_CLK);
            check_value("drp_done", 32'd1, 32'(drp_done));
        end
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        report_counts();
        if (mismatch_count + other_count + u_pipe_drp_top.u_assert.assert_fail_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- sim.f
verilog/pipe_drp_pkg.sv
verilog/drp_input_sync.sv
verilog/drp_attr_table.sv
verilog/drp_rmw_sequencer.sv
verilog/pipe_drp_top.sv
verif/pipe_drp_assertions.sv
verif/tb_pipe_drp.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_pipe_drp
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert -j 0
RUN_ARGS  := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
PASS_MSG  := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
